// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // width of one instruction word.
  localparam int ilen = 32;

  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jalr = 7'b1100111;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;
  localparam logic [6:0] op_fence = 7'b0001111;

  function automatic logic [6:0] opcode_of(input logic [ilen-1:0] inst);
    return inst[6:0];
  endfunction

  // b-type offset, 13 bits with bit 0 always zero.
  function automatic logic [ilen-1:0] imm_b(input logic [ilen-1:0] inst);
    return {{(ilen - 12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  endfunction

  // j-type offset, 21 bits with bit 0 always zero.
  function automatic logic [ilen-1:0] imm_j(input logic [ilen-1:0] inst);
    return {{(ilen - 20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  endfunction

endpackage

// ==== logic/fetch_pkg.sv ====
package fetch_pkg;

  localparam int xlen = 32;

  // first fetch address after reset.
  localparam logic [xlen-1:0] pc_init = 32'h8000_0000;

  // predictor tables.
  localparam int pht_size = 64;
  localparam int btb_size = 16;
  localparam int counter_bits = 3;

  localparam int icache_lines = 32;

  // tables are indexed by word address, so pc bits [1:0] are skipped.
  localparam int pht_index_bits = $clog2(pht_size);
  localparam int btb_index_bits = $clog2(btb_size);
  localparam int icache_index_bits = $clog2(icache_lines);
  localparam int icache_tag_bits = xlen - icache_index_bits - 2;

endpackage

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] pc,
  input  logic [fetch_pkg::xlen-1:0] inst,
  input  logic [fetch_pkg::xlen-1:0] npc,
  input  logic [fetch_pkg::xlen-1:0] rpc,
  input  logic                       jen,
  input  logic                       ben,
  input  logic                       fence_time,
  output logic [fetch_pkg::xlen-1:0] pnpc
);

  logic [fetch_pkg::counter_bits-1:0] pht [fetch_pkg::pht_size];
  logic [fetch_pkg::xlen-1:0]         btb [fetch_pkg::btb_size];
  logic [fetch_pkg::btb_size-1:0]     btb_valid;

  logic [fetch_pkg::pht_index_bits-1:0] pht_idx;
  logic [fetch_pkg::pht_index_bits-1:0] pht_train_idx;
  logic [fetch_pkg::btb_index_bits-1:0] btb_idx;
  logic [fetch_pkg::btb_index_bits-1:0] btb_train_idx;
  logic [6:0]                           opcode;
  logic [fetch_pkg::counter_bits-1:0]   train_count;
  logic                                 fell_through;

  assign opcode = rv_isa_pkg::opcode_of(inst);
  assign pht_idx = pc[fetch_pkg::pht_index_bits+1:2];
  assign btb_idx = pc[fetch_pkg::btb_index_bits+1:2];
  assign pht_train_idx = rpc[fetch_pkg::pht_index_bits+1:2];
  assign btb_train_idx = rpc[fetch_pkg::btb_index_bits+1:2];

  assign train_count = pht[pht_train_idx];
  // a resolved branch that went to the next word counts as not taken.
  assign fell_through = (npc == rpc + 4);

  always_comb begin
    if (opcode == rv_isa_pkg::op_jalr && btb_valid[btb_idx]) begin
      pnpc = btb[btb_idx];
    end else if (opcode == rv_isa_pkg::op_branch &&
                 pht[pht_idx][fetch_pkg::counter_bits-1]) begin
      pnpc = pc + rv_isa_pkg::imm_b(inst);
    end else if (opcode == rv_isa_pkg::op_jal) begin
      pnpc = pc + rv_isa_pkg::imm_j(inst);
    end else begin
      pnpc = pc + 4;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || fence_time) begin
      for (int i = 0; i < fetch_pkg::pht_size; i++) begin
        pht[i] <= '0;
      end
      btb_valid <= '0;
    end else begin
      if (jen) begin
        btb_valid[btb_train_idx] <= 1'b1;
      end
      // saturating counter, 0 is strongly not taken.
      if (ben) begin
        if (fell_through) begin
          if (train_count != '0) begin
            pht[pht_train_idx] <= train_count - 1'b1;
          end
        end else if (train_count != '1) begin
          pht[pht_train_idx] <= train_count + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (jen && !fence_time) begin
      btb[btb_train_idx] <= npc;
    end
  end

endmodule

// ==== logic/instruction_cache.sv ====
`timescale 1ns/1ps

module instruction_cache (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] fetch_pc,
  input  logic                       invalidate,
  input  logic                       flush_pipeline,
  output logic [fetch_pkg::xlen-1:0] inst,
  output logic                       hit,
  output logic [fetch_pkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       bus_ready,
  input  logic [fetch_pkg::xlen-1:0] rdata,
  input  logic                       rvalid
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } state_t;

  state_t state;

  logic [fetch_pkg::icache_tag_bits-1:0] tag_store [fetch_pkg::icache_lines];
  logic [fetch_pkg::xlen-1:0]            data_store [fetch_pkg::icache_lines];
  logic [fetch_pkg::icache_lines-1:0]    line_valid;

  logic [fetch_pkg::icache_index_bits-1:0] fetch_index;
  logic [fetch_pkg::icache_tag_bits-1:0]   fetch_tag;
  logic [fetch_pkg::xlen-1:0]              miss_addr;
  logic [fetch_pkg::icache_index_bits-1:0] miss_index;
  logic [fetch_pkg::icache_tag_bits-1:0]   miss_tag;
  logic                                    start_miss;
  logic                                    fill;

  assign fetch_index = fetch_pc[fetch_pkg::icache_index_bits+1:2];
  assign fetch_tag = fetch_pc[fetch_pkg::xlen-1:fetch_pkg::icache_index_bits+2];
  assign miss_index = miss_addr[fetch_pkg::icache_index_bits+1:2];
  assign miss_tag = miss_addr[fetch_pkg::xlen-1:fetch_pkg::icache_index_bits+2];

  assign hit = line_valid[fetch_index] && (tag_store[fetch_index] == fetch_tag);
  assign inst = data_store[fetch_index];

  // the pc changes on a flush edge, so no refill is started for it.
  assign start_miss = (state == st_idle) && !hit && !flush_pipeline;
  assign fill = (state == st_wait) && rvalid;

  assign araddr = miss_addr;
  assign arvalid = (state == st_request);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (start_miss) begin
            state <= st_request;
          end
        end
        st_request: begin
          if (bus_ready) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (rvalid) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (start_miss) begin
      miss_addr <= fetch_pc;
    end
  end

  // invalidation wins over a fill landing in the same cycle.
  always_ff @(posedge clock) begin
    if (reset || invalidate) begin
      line_valid <= '0;
    end else if (fill) begin
      line_valid[miss_index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      tag_store[miss_index] <= miss_tag;
      data_store[miss_index] <= rdata;
    end
  end

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] npc,
  input  logic                       sys_retire,
  input  logic                       flush_pipeline,
  input  logic                       fence_i,
  input  logic                       prev_valid,
  input  logic                       next_ready,
  input  logic [fetch_pkg::xlen-1:0] pnpc,
  output logic [fetch_pkg::xlen-1:0] inst,
  output logic [fetch_pkg::xlen-1:0] pc,
  output logic                       out_valid,
  output logic                       out_ready,
  output logic [fetch_pkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       bus_ready,
  input  logic [fetch_pkg::xlen-1:0] rdata,
  input  logic                       rvalid
);

  logic [6:0] opcode;
  logic       is_sys;
  logic       sys_hazard;
  logic       hit;
  logic       valid;
  logic       take;

  // system and fence words stall fetch until the backend retires them.
  assign opcode = rv_isa_pkg::opcode_of(inst);
  assign is_sys = (opcode == rv_isa_pkg::op_system) || (opcode == rv_isa_pkg::op_fence);

  assign valid = hit && !sys_hazard && !flush_pipeline;
  assign take = valid && next_ready;
  assign out_valid = valid;
  assign out_ready = !valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= fetch_pkg::pc_init;
      sys_hazard <= 1'b0;
    end else if (flush_pipeline) begin
      pc <= npc;
      sys_hazard <= 1'b0;
    end else begin
      if (prev_valid && sys_retire) begin
        pc <= npc;
        sys_hazard <= 1'b0;
      end
      if (take) begin
        pc <= pnpc;
        if (is_sys) begin
          sys_hazard <= 1'b1;
        end
      end
    end
  end

  instruction_cache icache0 (
    .clock          (clock),
    .reset          (reset),
    .fetch_pc       (pc),
    .invalidate     (fence_i),
    .flush_pipeline (flush_pipeline),
    .inst           (inst),
    .hit            (hit),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .bus_ready      (bus_ready),
    .rdata          (rdata),
    .rvalid         (rvalid)
  );

endmodule

// ==== logic/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
  input  logic                       clock,
  input  logic                       reset,
  input  logic [fetch_pkg::xlen-1:0] npc,
  input  logic [fetch_pkg::xlen-1:0] rpc,
  input  logic                       jen,
  input  logic                       ben,
  input  logic                       sys_retire,
  input  logic                       flush_pipeline,
  input  logic                       fence_time,
  input  logic                       fence_i,
  input  logic                       prev_valid,
  input  logic                       next_ready,
  output logic [fetch_pkg::xlen-1:0] inst,
  output logic [fetch_pkg::xlen-1:0] pc,
  output logic [fetch_pkg::xlen-1:0] pnpc,
  output logic                       out_valid,
  output logic                       out_ready,
  output logic [fetch_pkg::xlen-1:0] araddr,
  output logic                       arvalid,
  input  logic                       bus_ready,
  input  logic [fetch_pkg::xlen-1:0] rdata,
  input  logic                       rvalid
);

  // pc and inst go out and also feed the predictor, whose pnpc loops back.
  fetch_unit ifu0 (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .sys_retire     (sys_retire),
    .flush_pipeline (flush_pipeline),
    .fence_i        (fence_i),
    .prev_valid     (prev_valid),
    .next_ready     (next_ready),
    .pnpc           (pnpc),
    .inst           (inst),
    .pc             (pc),
    .out_valid      (out_valid),
    .out_ready      (out_ready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .bus_ready      (bus_ready),
    .rdata          (rdata),
    .rvalid         (rvalid)
  );

  branch_predictor bpu0 (
    .clock      (clock),
    .reset      (reset),
    .pc         (pc),
    .inst       (inst),
    .npc        (npc),
    .rpc        (rpc),
    .jen        (jen),
    .ben        (ben),
    .fence_time (fence_time),
    .pnpc       (pnpc)
  );

endmodule

// ==== verification/fetch_sva.sv ====
`timescale 1ns/1ps

module fetch_sva (
  input logic        clock,
  input logic        reset,
  input logic [31:0] pc,
  input logic [31:0] araddr,
  input logic        arvalid,
  input logic        bus_ready,
  input logic        out_valid,
  input logic        out_ready,
  input logic        next_ready,
  input logic        flush_pipeline
);

  // a bus request holds its address until accepted.
  assert property (@(posedge clock) disable iff (reset)
    arvalid && !bus_ready |=> arvalid && $stable(araddr))
    else $error("bus request dropped or changed before accept");

  assert property (@(posedge clock) out_ready == !out_valid)
    else $error("out_ready is not the inverse of out_valid");

  // stalled output keeps its pc.
  assert property (@(posedge clock) disable iff (reset)
    out_valid && !next_ready && !flush_pipeline |=> $stable(pc))
    else $error("pc moved while the output was stalled");

  assert property (@(posedge clock) reset |=> pc == fetch_pkg::pc_init && !arvalid)
    else $error("pc or bus request wrong after reset");

endmodule

// ==== verification/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
  input  logic        clock,
  input  logic        reset,
  input  logic        done,
  input  logic [31:0] pc,
  input  logic [31:0] inst,
  input  logic [31:0] pnpc,
  input  logic        out_valid,
  input  logic        next_ready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  input  logic        bus_ready,
  input  logic [31:0] rdata,
  input  logic        rvalid,
  input  logic [31:0] npc,
  input  logic [31:0] rpc,
  input  logic        jen,
  input  logic        ben,
  input  logic        flush_pipeline,
  input  logic        fence_time,
  input  logic        fence_i,
  input  logic        sys_retire,
  input  logic        prev_valid,
  input  logic [31:0] pc_word,
  input  logic [31:0] araddr_word,
  output int          errors
);

  logic [fetch_pkg::counter_bits-1:0] pht [fetch_pkg::pht_size];
  logic [31:0]                        btb [fetch_pkg::btb_size];
  logic [fetch_pkg::btb_size-1:0]     btb_v;
  logic [31:0]                        tags [fetch_pkg::icache_lines];
  logic [fetch_pkg::icache_lines-1:0] line_v;
  logic [31:0]                        expect_pc;
  logic [31:0]                        accept_addr;
  logic [31:0]                        accept_word;
  logic                               pending;
  logic                               hazard;
  logic                               arvalid_q;
  logic                               after_reset;
  int                                 checks [1:6];
  int                                 fails [1:6];

  task automatic check(input int b, input logic ok, input string msg);
    checks[b]++;
    if (!ok) begin
      fails[b]++;
      $display("** Error @%0t: behavior %0d, %s", $time, b, msg);
    end
  endtask

  function automatic int line_of(input logic [31:0] a);
    return (a >> 2) % fetch_pkg::icache_lines;
  endfunction

  // memory holds only forward branches by 8 and jumps by 12.
  function automatic logic [31:0] predict(input logic [31:0] a, input logic [31:0] w);
    int p;
    int t;
    p = (a >> 2) % fetch_pkg::pht_size;
    t = (a >> 2) % fetch_pkg::btb_size;
    case (w[6:0])
      rv_isa_pkg::op_jalr: return btb_v[t] ? btb[t] : a + 4;
      rv_isa_pkg::op_branch: return pht[p][fetch_pkg::counter_bits-1] ? a + 8 : a + 4;
      rv_isa_pkg::op_jal: return a + 12;
      default: return a + 4;
    endcase
  endfunction

  always @(posedge clock) begin
    int p;
    int t;
    p = (rpc >> 2) % fetch_pkg::pht_size;
    t = (rpc >> 2) % fetch_pkg::btb_size;
    if (reset) begin
      for (int i = 0; i < fetch_pkg::pht_size; i++) begin
        pht[i] = '0;
      end
      btb_v = '0;
      line_v = '0;
      hazard = 1'b0;
      pending = 1'b0;
      arvalid_q = 1'b0;
      after_reset = 1'b1;
      expect_pc = fetch_pkg::pc_init;
    end else begin
      if (after_reset) begin
        check(1, pc == fetch_pkg::pc_init && !arvalid && !out_valid, "state after reset");
        after_reset = 1'b0;
      end
      check(6, !(hazard && out_valid), "output valid while a system word is pending");
      if (arvalid && !arvalid_q) begin
        check(5, !(line_v[line_of(araddr)] && tags[line_of(araddr)] == araddr),
              $sformatf("bus request for cached address %h", araddr));
      end
      // only one read may be outstanding, so no request while a response is due.
      if (rvalid) begin
        check(2, pending && !arvalid && rdata == accept_word,
              $sformatf("bus response %h", rdata));
        line_v[line_of(accept_addr)] = 1'b1;
        tags[line_of(accept_addr)] = accept_addr;
        pending = 1'b0;
      end
      if (arvalid && bus_ready) begin
        accept_addr = araddr;
        accept_word = araddr_word;
        pending = 1'b1;
      end
      if (out_valid && next_ready) begin
        check(2, inst == pc_word, $sformatf("inst %h at pc %h, expected %h", inst, pc, pc_word));
        check(3, pnpc == predict(pc, pc_word),
              $sformatf("pnpc %h at pc %h, expected %h", pnpc, pc, predict(pc, pc_word)));
        check(4, pc == expect_pc, $sformatf("pc %h, expected %h", pc, expect_pc));
        check(5, line_v[line_of(pc)] && tags[line_of(pc)] == pc,
              $sformatf("fetch of uncached pc %h", pc));
        expect_pc = predict(pc, pc_word);
        hazard = pc_word[6:0] == rv_isa_pkg::op_system ||
                 pc_word[6:0] == rv_isa_pkg::op_fence;
      end
      if (flush_pipeline || (prev_valid && sys_retire)) begin
        expect_pc = npc;
        hazard = 1'b0;
      end
      arvalid_q = arvalid;
      // clearing the predictor overrides training in the same cycle.
      if (fence_time) begin
        for (int i = 0; i < fetch_pkg::pht_size; i++) begin
          pht[i] = '0;
        end
        btb_v = '0;
      end else begin
        if (jen) begin
          btb[t] = npc;
          btb_v[t] = 1'b1;
        end
        if (ben && npc == rpc + 4 && pht[p] != '0) begin
          pht[p] = pht[p] - 1'b1;
        end else if (ben && npc != rpc + 4 && pht[p] != '1) begin
          pht[p] = pht[p] + 1'b1;
        end
      end
      if (fence_i) begin
        line_v = '0;
      end
    end
  end

  always @(posedge done) begin
    int total;
    int bad;
    total = 0;
    bad = 0;
    for (int b = 1; b <= 6; b++) begin
      if (checks[b] == 0) begin
        fails[b]++;
        $display("behavior %0d was never exercised", b);
      end
      $display("behavior %0d: %0d checks, %0d errors", b, checks[b], fails[b]);
      total += checks[b];
      bad += fails[b];
    end
    $display("totals: %0d checks, %0d errors", total, bad);
    errors = bad;
  end

endmodule

// ==== verification/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

  localparam int run_takes = 4000;
  localparam int cycle_limit = 80000;

  logic        clock;
  logic        reset;
  logic [31:0] npc;
  logic [31:0] rpc;
  logic        jen;
  logic        ben;
  logic        sys_retire;
  logic        flush_pipeline;
  logic        fence_time;
  logic        fence_i;
  logic        prev_valid;
  logic        next_ready;
  logic [31:0] inst;
  logic [31:0] pc;
  logic [31:0] pnpc;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        bus_ready;
  logic [31:0] rdata;
  logic        rvalid;
  logic [31:0] pc_word;
  logic [31:0] araddr_word;
  logic        done;
  int          errors;

  logic [31:0] lfsr;
  logic        took;
  logic [31:0] took_pc;
  logic [31:0] took_inst;
  logic [31:0] took_pnpc;
  logic        accepted;
  logic [31:0] accept_addr;
  logic        resp_busy;
  int          resp_wait;
  logic [31:0] resp_addr;
  int          retire_wait;
  logic [31:0] retire_pc;
  int          takes;
  int          cycles;

  fetch_top dut0 (.*);
  fetch_checker chk0 (.*);
  bind fetch_top fetch_sva sva0 (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // word kind comes from a fold of all word-address bits.
  function automatic logic [31:0] memory_word(input logic [31:0] a);
    logic [29:0] w;
    logic [2:0]  sel;
    w = a[31:2];
    sel = '0;
    for (int i = 0; i < 30; i += 3) begin
      sel ^= w[i +: 3];
    end
    case (sel)
      3'd1: return 32'h0000_0463;
      3'd3: return 32'h00c0_006f;
      3'd5: return 32'h0000_8067;
      3'd7: return w[3] ? 32'h0000_0073 : 32'h0000_000f;
      default: return {w[11:0], 20'h00013};
    endcase
  endfunction

  assign pc_word = memory_word(pc);
  assign araddr_word = memory_word(araddr);

  task automatic drive_inputs();
    logic [31:0] target;
    jen = 1'b0;
    ben = 1'b0;
    flush_pipeline = 1'b0;
    sys_retire = 1'b0;
    prev_valid = 1'b0;
    rvalid = 1'b0;
    next_ready = rand_bits(2) != 0;
    bus_ready = rand_bits(1) != 0;
    fence_i = rand_bits(6) == 0;
    fence_time = rand_bits(6) == 0;
    if (accepted) begin
      resp_busy = 1'b1;
      resp_wait = rand_bits(2);
      resp_addr = accept_addr;
    end
    if (resp_busy && resp_wait == 0) begin
      rvalid = 1'b1;
      rdata = memory_word(resp_addr);
      resp_busy = 1'b0;
    end else if (resp_busy) begin
      resp_wait--;
    end
    if (retire_wait > 0) begin
      retire_wait--;
      if (retire_wait == 0) begin
        prev_valid = 1'b1;
        sys_retire = 1'b1;
        npc = retire_pc;
      end
    end
    // backend resolves the word taken in the previous cycle.
    if (took) begin
      target = took_pc + 4;
      rpc = took_pc;
      case (took_inst[6:0])
        rv_isa_pkg::op_branch: begin
          ben = 1'b1;
          if (rand_bits(1)) begin
            target = took_pc + 8;
          end
        end
        rv_isa_pkg::op_jalr: begin
          jen = 1'b1;
          target = fetch_pkg::pc_init + (rand_bits(8) << 2);
        end
        rv_isa_pkg::op_jal: target = took_pc + 12;
        rv_isa_pkg::op_system, rv_isa_pkg::op_fence: begin
          retire_wait = rand_bits(3) + 1;
          retire_pc = took_pc + 4;
        end
        default: ;
      endcase
      npc = target;
      flush_pipeline = target != took_pnpc;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    {npc, rpc, rdata} = '0;
    {jen, ben, sys_retire, flush_pipeline, fence_time, fence_i} = '0;
    {prev_valid, next_ready, bus_ready, rvalid, done} = '0;
    lfsr = 32'he2ad_9571;
    {took, accepted, resp_busy} = '0;
    {resp_wait, retire_wait, takes, cycles} = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;
    while (takes < run_takes && cycles < cycle_limit) begin
      @(negedge clock);
      drive_inputs();
      #1;
      took = out_valid && next_ready;
      took_pc = pc;
      took_inst = inst;
      took_pnpc = pnpc;
      accepted = arvalid && bus_ready;
      accept_addr = araddr;
      takes += took;
      cycles++;
    end
    done = 1'b1;
    #1;
    if (takes < run_takes) begin
      $display("timeout: only %0d of %0d words fetched", takes, run_takes);
    end
    if (errors == 0 && takes >= run_takes) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/branch_predictor.sv
logic/instruction_cache.sv
logic/fetch_unit.sv
logic/fetch_top.sv
verification/fetch_sva.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: rv_fetch

sources:
  - logic/rv_isa_pkg.sv
  - logic/fetch_pkg.sv
  - logic/branch_predictor.sv
  - logic/instruction_cache.sv
  - logic/fetch_unit.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - verification/fetch_sva.sv
      - verification/fetch_checker.sv
      - verification/fetch_tb.sv
